// File: Bender.yml
package:
  name: ipack

sources:
  - rtl/ipack_pkg.sv
  - rtl/ipack_fetch_in.sv
  - rtl/ipack_len_decode.sv
  - rtl/ipack_hw_buf.sv
  - rtl/ipack_retire.sv
  - rtl/ipack_top.sv
  - target: test
    files:
      - bench/ipack_asserts.sv
      - bench/ipack_tb.sv

// File: bench/ipack_asserts.sv
// checks on the packer top; all properties are off during reset, all+two together is legal
`timescale 1ns/1ns

module ipack_asserts (
  input logic                  forever_cpuclk,
  input logic                  rst_n,
  input ipack_pkg::flush_src_t flush_src,
  input logic                  ibuf_stall,
  input ipack_pkg::ibuf_req_t  ibuf_req,
  input logic                  ibuf_empty,
  input logic                  ibuf_full
);

  // number of failed properties so far
  int fail_cnt = 0;

  // no window handed out under back-pressure
  assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    ibuf_stall |-> !ibuf_req.vld)
    else begin
      fail_cnt++;
      $error("ibuf_req.vld high while ibuf_stall is high");
    end

  // all rides on top of two for the trailing parcel, one stands alone
  assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    !(ibuf_req.one && (ibuf_req.two || ibuf_req.all)))
    else begin
      fail_cnt++;
      $error("count code one overlaps two or all");
    end

  assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    !(ibuf_empty && ibuf_full))
    else begin
      fail_cnt++;
      $error("ibuf_empty and ibuf_full both high");
    end

  // any flush source empties the buffer at the next edge
  assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    (flush_src != '0) |=> ibuf_empty)
    else begin
      fail_cnt++;
      $error("buffer not empty one cycle after a flush");
    end

endmodule

bind ipack_top ipack_asserts u_asserts (
  .forever_cpuclk (forever_cpuclk),
  .rst_n          (rst_n),
  .flush_src      (flush_src),
  .ibuf_stall     (ibuf_stall),
  .ibuf_req       (ibuf_req),
  .ibuf_empty     (ibuf_empty),
  .ibuf_full      (ibuf_full)
);

// File: bench/ipack_tb.sv
// unaligned fetches go only into an empty buffer; entry payloads start unknown on both sides
`timescale 1ns/1ns

module ipack_tb;

  logic                  forever_cpuclk;
  logic                  rst_n;
  ipack_pkg::fetch_req_t fetch;
  logic                  pcgen_chgflw;
  logic                  inst_mask;
  ipack_pkg::flush_src_t flush_src;
  logic                  ibuf_stall;
  ipack_pkg::ibuf_req_t  ibuf_req;
  logic                  ibuf_empty;
  logic                  ibuf_full;
  logic                  pcgen_reissue;

  // reference copy of entry0..entry2
  logic [2:0]                 m_vld;
  logic [2:0]                 m_err;
  ipack_pkg::halfword_t [2:0] m_inst;

  integer seed;
  int     errors;
  int     test_errors;
  int     assert_errors;
  int     tests;
  string  test_name;

  ipack_top uut (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .fetch          (fetch),
    .pcgen_chgflw   (pcgen_chgflw),
    .inst_mask      (inst_mask),
    .flush_src      (flush_src),
    .ibuf_stall     (ibuf_stall),
    .ibuf_req       (ibuf_req),
    .ibuf_empty     (ibuf_empty),
    .ibuf_full      (ibuf_full),
    .pcgen_reissue  (pcgen_reissue)
  );

  always #10 forever_cpuclk = ~forever_cpuclk;

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic logic is_long(input ipack_pkg::halfword_t p);
    return p[1:0] == 2'b11;
  endfunction

  function automatic ipack_pkg::ibuf_req_t expect_req(input logic stall);
    ipack_pkg::ibuf_req_t r;
    logic h0;
    logic h1s;
    logic h1l;
    logic h2s;
    h0  = m_vld[0] & is_long(m_inst[0]);
    h1s = m_vld[1] & ~is_long(m_inst[1]);
    h1l = m_vld[1] & is_long(m_inst[1]);
    h2s = m_vld[2] & ~is_long(m_inst[2]);
    r.window.halves[2] = m_inst[2];
    if (m_vld[0]) begin
      r.window.split.first = {m_inst[1], m_inst[0]};
    end else if (m_vld[1]) begin
      r.window.split.first = {m_inst[2], m_inst[1]};
    end else begin
      r.window.split.first = {m_inst[2], m_inst[2]};
    end
    r.vld = (m_vld[1] | h2s) & ~stall;
    r.two = (h0 | h1s) & h2s;
    r.one = (~h0 & h1s & ~h2s) | (~m_vld[1] & h2s);
    r.all = h0 & m_vld[1] & h2s;
    r.acc_err[0] = (~h0 & m_vld[1] & m_err[1]) | (~m_vld[1] & h2s & m_err[2])
                 | (h0 & m_vld[1] & m_err[0]);
    r.acc_err[1] = (~h0 & h1l & m_vld[2] & m_err[2]) | (~h0 & h1s & h2s & m_err[2])
                 | (h0 & m_vld[1] & m_err[1]);
    r.acc_err[2] = r.all & m_err[2];
    return r;
  endfunction

  // next entry state from the inputs sampled at the coming edge
  task automatic step_model();
    logic [2:0] nv;
    logic [2:0] cre;
    logic       fq_vld;
    logic       h0;
    logic       h1s;
    logic       h2s;
    logic       h2l;
    fq_vld = fetch.vld & ~pcgen_chgflw & ~inst_mask;
    h0     = m_vld[0] & is_long(m_inst[0]);
    h1s    = m_vld[1] & ~is_long(m_inst[1]);
    h2s    = m_vld[2] & ~is_long(m_inst[2]);
    h2l    = m_vld[2] & is_long(m_inst[2]);
    cre[2] = fq_vld & ~(m_vld[2] & ibuf_stall);
    cre[1] = fq_vld & ~fetch.unalign & ~((m_vld[1] | h2s) & ibuf_stall);
    cre[0] = ~ibuf_stall & h2l & (~m_vld[1] | (~h0 & h1s) | (h0 & m_vld[1]));
    // entry0 takes the old entry2 parcel, so it goes first
    if (cre[0]) begin
      m_inst[0] = m_inst[2];
      m_err[0]  = m_err[2];
    end
    if (cre[1]) begin
      m_inst[1] = fetch.word[0];
      m_err[1]  = fetch.acc_err;
    end
    if (cre[2]) begin
      m_inst[2] = fetch.word[1];
      m_err[2]  = fetch.acc_err;
    end
    nv[0] = cre[0] | (m_vld[0] & (ibuf_stall | ~m_vld[1]));
    nv[1] = cre[1] | (m_vld[1] & ibuf_stall);
    nv[2] = cre[2] | (m_vld[2] & ibuf_stall);
    m_vld = (flush_src != '0) ? 3'b000 : nv;
  endtask

  // --------------------------------------------------
  // checking and bookkeeping
  // --------------------------------------------------
  task automatic check(input string what, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("** Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  always @(negedge forever_cpuclk) begin : compare_outputs
    ipack_pkg::ibuf_req_t exp_req;
    if (!rst_n) begin
      m_vld = 3'b000;
    end else begin
      exp_req = expect_req(ibuf_stall);
      check("ibuf_req", exp_req, ibuf_req);
      check("ibuf_empty", m_vld == 3'b000, ibuf_empty);
      check("ibuf_full", &m_vld, ibuf_full);
      check("pcgen_reissue", ibuf_stall & fetch.vld, pcgen_reissue);
      step_model();
    end
  end

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    // property failures of the bound checker count against the current test
    errors        = errors + uut.u_asserts.fail_cnt - assert_errors;
    assert_errors = uut.u_asserts.fail_cnt;
    tests++;
    $display("test %-10s %s, %0d errors", test_name,
             (errors == test_errors) ? "ok" : "failed", errors - test_errors);
  endtask

  task automatic abort_run(input string what);
    $display("timed out waiting for %s in test %s", what, test_name);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic wait_req_vld(input int limit);
    int n;
    n = 0;
    @(negedge forever_cpuclk);
    while (!ibuf_req.vld && n < limit) begin
      @(negedge forever_cpuclk);
      n++;
    end
    if (!ibuf_req.vld) begin
      abort_run("ibuf_req.vld");
    end
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  task automatic drive_word(input ipack_pkg::halfword_t hi, input ipack_pkg::halfword_t lo,
                            input logic unalign, input logic err);
    fetch.vld     <= 1'b1;
    fetch.unalign <= unalign;
    fetch.acc_err <= err;
    fetch.word    <= {hi, lo};
  endtask

  task automatic send_word(input ipack_pkg::halfword_t hi, input ipack_pkg::halfword_t lo,
                           input logic unalign, input logic err);
    @(posedge forever_cpuclk);
    drive_word(hi, lo, unalign, err);
    @(posedge forever_cpuclk);
    fetch.vld <= 1'b0;
  endtask

  initial begin : stimulus
    logic [31:0] r;
    forever_cpuclk = 1'b0;
    rst_n          = 1'b0;
    fetch          = '0;
    pcgen_chgflw   = 1'b0;
    inst_mask      = 1'b0;
    flush_src      = '0;
    ibuf_stall     = 1'b0;
    seed           = 32'h6f647c73;
    errors         = 0;
    assert_errors  = 0;
    tests          = 0;
    start_test("reset");
    repeat (3) @(posedge forever_cpuclk);
    rst_n <= 1'b1;
    @(negedge forever_cpuclk);
    check("status", 3'b010, {ibuf_req.vld, ibuf_empty, ibuf_full});
    end_test();

    start_test("two_short");
    send_word(16'h4561, 16'h1235, 1'b0, 1'b0);
    wait_req_vld(8);
    check("count", 3'b010, {ibuf_req.one, ibuf_req.two, ibuf_req.all});
    check("low", 16'h1235, ibuf_req.window.halves[0]);
    check("middle", 16'h4561, ibuf_req.window.halves[1]);
    end_test();

    start_test("single");
    send_word(16'h00c8, 16'h0a23, 1'b0, 1'b0);
    wait_req_vld(8);
    check("count", 3'b000, {ibuf_req.one, ibuf_req.two, ibuf_req.all});
    check("first", 32'h00c8_0a23, ibuf_req.window.split.first);
    // unaligned, high half only
    send_word(16'h789d, 16'hffff, 1'b1, 1'b0);
    wait_req_vld(8);
    check("count", 3'b100, {ibuf_req.one, ibuf_req.two, ibuf_req.all});
    check("low", 16'h789d, ibuf_req.window.halves[0]);
    end_test();

    start_test("straddle");
    send_word(16'h5007, 16'h1235, 1'b0, 1'b0);
    wait_req_vld(8);
    check("count", 3'b100, {ibuf_req.one, ibuf_req.two, ibuf_req.all});
    check("low", 16'h1235, ibuf_req.window.halves[0]);
    send_word(16'h789d, 16'h00c8, 1'b0, 1'b0);
    wait_req_vld(8);
    check("one_all", 2'b01, {ibuf_req.one, ibuf_req.all});
    check("first", 32'h00c8_5007, ibuf_req.window.split.first);
    check("third", 16'h789d, ibuf_req.window.halves[2]);
    end_test();

    start_test("acc_err");
    send_word(16'h4561, 16'h1235, 1'b0, 1'b1);
    wait_req_vld(8);
    check("err", 3'b011, ibuf_req.acc_err);
    send_word(16'h789d, 16'hffff, 1'b1, 1'b1);
    wait_req_vld(8);
    check("err", 3'b001, ibuf_req.acc_err);
    send_word(16'h5007, 16'h1235, 1'b0, 1'b0);
    wait_req_vld(8);
    send_word(16'h789d, 16'h00c8, 1'b0, 1'b1);
    wait_req_vld(8);
    check("err", 3'b110, ibuf_req.acc_err);
    end_test();

    start_test("stall");
    @(posedge forever_cpuclk);
    drive_word(16'h4561, 16'h1235, 1'b0, 1'b0);
    @(posedge forever_cpuclk);
    ibuf_stall <= 1'b1;
    drive_word(16'h789d, 16'h0a23, 1'b0, 1'b0);
    repeat (3) begin
      @(negedge forever_cpuclk);
      check("vld_reissue", 2'b01, {ibuf_req.vld, pcgen_reissue});
    end
    @(posedge forever_cpuclk);
    ibuf_stall <= 1'b0;
    fetch.vld  <= 1'b0;
    wait_req_vld(8);
    check("held", 32'h4561_1235, ibuf_req.window.split.first);
    end_test();

    start_test("flush");
    for (int i = 0; i < 6; i++) begin
      @(posedge forever_cpuclk);
      drive_word(16'h4561, 16'h1235, 1'b0, 1'b0);
      @(posedge forever_cpuclk);
      fetch.vld  <= 1'b0;
      ibuf_stall <= 1'b1;
      @(posedge forever_cpuclk);
      flush_src <= ipack_pkg::flush_src_t'(6'b1 << i);
      @(posedge forever_cpuclk);
      flush_src  <= '0;
      ibuf_stall <= 1'b0;
      @(negedge forever_cpuclk);
      check("empty", 1'b1, ibuf_empty);
    end
    end_test();

    start_test("masks");
    @(posedge forever_cpuclk);
    pcgen_chgflw <= 1'b1;
    drive_word(16'h4561, 16'h1235, 1'b0, 1'b0);
    @(posedge forever_cpuclk);
    pcgen_chgflw <= 1'b0;
    inst_mask    <= 1'b1;
    @(posedge forever_cpuclk);
    inst_mask <= 1'b0;
    fetch.vld <= 1'b0;
    @(negedge forever_cpuclk);
    check("empty_vld", 2'b10, {ibuf_empty, ibuf_req.vld});
    end_test();

    start_test("random");
    for (int n = 0; n < 400; n++) begin
      @(posedge forever_cpuclk);
      r = $random(seed);
      fetch.vld     <= r[0] | r[1];
      fetch.unalign <= r[2] & (m_vld == 3'b000);
      fetch.acc_err <= (r[5:3] == 3'd0);
      fetch.word    <= $random(seed);
      ibuf_stall    <= (r[7:6] == 2'd0);
      pcgen_chgflw  <= (r[11:8] == 4'd0);
      inst_mask     <= (r[15:12] == 4'd0);
      flush_src     <= (r[20:16] == 5'd0) ?
                       ipack_pkg::flush_src_t'(6'b1 << (r[23:21] % 6)) : '0;
    end
    @(posedge forever_cpuclk);
    fetch        <= '0;
    ibuf_stall   <= 1'b0;
    pcgen_chgflw <= 1'b0;
    inst_mask    <= 1'b0;
    flush_src    <= '0;
    repeat (3) @(negedge forever_cpuclk);
    end_test();

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: ipack.f
rtl/ipack_pkg.sv
rtl/ipack_fetch_in.sv
rtl/ipack_len_decode.sv
rtl/ipack_hw_buf.sv
rtl/ipack_retire.sv
rtl/ipack_top.sv
bench/ipack_asserts.sv
bench/ipack_tb.sv

// File: rtl/ipack_fetch_in.sv
// combinational front of the packer; a masked fetch is dropped outright, never held back
`timescale 1ns/1ns

module ipack_fetch_in (
  input  logic                   forever_cpuclk,
  input  logic                   rst_n,
  input  ipack_pkg::fetch_req_t  fetch,
  input  logic                   pcgen_chgflw,
  input  logic                   inst_mask,
  input  ipack_pkg::flush_src_t  flush_src,
  output ipack_pkg::fetch_req_t  fetch_q,
  output logic                   buf_flush
);

  // clock and reset only keep this stage in the same domain as the buffer;
  // everything below settles within the fetch cycle
  logic fetch_kill;

  // --------------------------------------------------
  // fetch qualification
  // --------------------------------------------------
  // pc generator redirect or vector mask kills this word
  assign fetch_kill = pcgen_chgflw | inst_mask;

  always_comb begin
    fetch_q     = fetch;
    fetch_q.vld = fetch.vld & ~fetch_kill;
  end

  // --------------------------------------------------
  // flush merge
  // --------------------------------------------------
  // any of the six sources empties all entries at the next edge
  assign buf_flush = flush_src.fe_flush
                   | flush_src.tar_pc
                   | flush_src.expt
                   | flush_src.chgflw
                   | flush_src.tail
                   | flush_src.tail_int;

endmodule

// File: rtl/ipack_hw_buf.sv
// three halfword entries; flush beats create beats retire, at most two fetch words in flight
`timescale 1ns/1ns

module ipack_hw_buf (
  input  logic                                         forever_cpuclk,
  input  logic                                         rst_n,
  input  ipack_pkg::fetch_req_t                        fetch_q,
  input  logic                                         buf_flush,
  input  logic                                         ibuf_stall,
  input  ipack_pkg::slot_class_t                       slot_class,
  output ipack_pkg::entry_t [ipack_pkg::ENTRY_CNT-1:0] entries
);

  // entry state
  logic [ipack_pkg::ENTRY_CNT-1:0]                vld_q;
  logic [ipack_pkg::ENTRY_CNT-1:0]                err_q;
  ipack_pkg::halfword_t [ipack_pkg::ENTRY_CNT-1:0] inst_q;

  // update controls
  logic [ipack_pkg::ENTRY_CNT-1:0]                create_en;
  logic [ipack_pkg::ENTRY_CNT-1:0]                retire_en;
  logic [ipack_pkg::ENTRY_CNT-1:0]                upd_err;
  ipack_pkg::halfword_t [ipack_pkg::ENTRY_CNT-1:0] upd_inst;
  logic                                           carry_32;

  // --------------------------------------------------
  // create conditions
  // --------------------------------------------------
  // high half of a 32-bit op moves down into entry0 when it cannot
  // be paired with anything this cycle
  assign carry_32 = ~vld_q[1]
                  | (~slot_class.h0_vld & slot_class.h1_16)
                  | (slot_class.h0_vld & vld_q[1]);

  assign create_en[0] = ~ibuf_stall & slot_class.h2_32 & carry_32;

  // unaligned fetch delivers only the high half
  assign create_en[1] = fetch_q.vld
                      & ~fetch_q.unalign
                      & ~((vld_q[1] | slot_class.h2_16) & ibuf_stall);

  assign create_en[2] = fetch_q.vld & ~(vld_q[2] & ibuf_stall);

  // --------------------------------------------------
  // retire conditions
  // --------------------------------------------------
  // entry0 leaves together with the entry1 half it completes
  assign retire_en[0] = ~ibuf_stall & vld_q[1];
  assign retire_en[1] = ~ibuf_stall;
  assign retire_en[2] = ~ibuf_stall;

  // --------------------------------------------------
  // new contents
  // --------------------------------------------------
  assign upd_inst[0] = inst_q[2];
  assign upd_err[0]  = err_q[2];
  assign upd_inst[1] = fetch_q.word[0];
  assign upd_err[1]  = fetch_q.acc_err;
  assign upd_inst[2] = fetch_q.word[1];
  assign upd_err[2]  = fetch_q.acc_err;

  // --------------------------------------------------
  // valid bits
  // --------------------------------------------------
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else if (buf_flush) begin
      vld_q <= '0;
    end else begin
      for (int i = 0; i < ipack_pkg::ENTRY_CNT; i++) begin
        if (create_en[i]) begin
          vld_q[i] <= 1'b1;
        end else if (retire_en[i]) begin
          vld_q[i] <= 1'b0;
        end
      end
    end
  end

  // payload, only meaningful while the matching valid is set
  always_ff @(posedge forever_cpuclk) begin
    for (int i = 0; i < ipack_pkg::ENTRY_CNT; i++) begin
      if (create_en[i]) begin
        inst_q[i] <= upd_inst[i];
        err_q[i]  <= upd_err[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < ipack_pkg::ENTRY_CNT; i++) begin
      entries[i].vld     = vld_q[i];
      entries[i].acc_err = err_q[i];
      entries[i].inst    = inst_q[i];
    end
  end

endmodule

// File: rtl/ipack_len_decode.sv
// length classification only; parcels with low bits other than 2'b11 count as 16-bit
`timescale 1ns/1ns

module ipack_len_decode (
  input  ipack_pkg::entry_t [ipack_pkg::ENTRY_CNT-1:0] entries,
  output ipack_pkg::slot_class_t                       slot_class
);

  // one flag per entry, set when the parcel starts a 32-bit instruction
  logic [ipack_pkg::ENTRY_CNT-1:0] is_32;

  // --------------------------------------------------
  // per-parcel length rule
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < ipack_pkg::ENTRY_CNT; i++) begin
      is_32[i] = (entries[i].inst[1:0] == ipack_pkg::LEN32_CODE);
    end
  end

  // --------------------------------------------------
  // class flags, qualified by entry valid
  // --------------------------------------------------
  // entry0 only ever holds the leading half of a straddling 32-bit op
  assign slot_class.h0_vld = entries[0].vld &  is_32[0];

  // current word, low half
  assign slot_class.h1_16  = entries[1].vld & ~is_32[1];
  assign slot_class.h1_32  = entries[1].vld &  is_32[1];

  // current word, high half
  assign slot_class.h2_16  = entries[2].vld & ~is_32[2];
  assign slot_class.h2_32  = entries[2].vld &  is_32[2];

endmodule

// File: rtl/ipack_pkg.sv
// shared types for the packer; three entries fixed by the 16/32-bit length rules, no 48-bit parcels
package ipack_pkg;

  // --------------------------------------------------
  // parcel and length constants
  // --------------------------------------------------
  localparam int HW_W = 16;

  // entry0 carry, entry1 low half, entry2 high half
  localparam int ENTRY_CNT = 3;

  // low two bits of a parcel that start a 32-bit instruction
  localparam logic [1:0] LEN32_CODE = 2'b11;

  typedef logic [HW_W-1:0] halfword_t;

  // --------------------------------------------------
  // input side
  // --------------------------------------------------
  typedef struct packed {
    logic fe_flush;
    logic tar_pc;
    logic expt;
    logic chgflw;
    logic tail;
    logic tail_int;
  } flush_src_t;

  // word[1] is the high half, word[0] the low half
  typedef struct packed {
    logic           vld;
    logic           unalign;
    logic           acc_err;
    halfword_t [1:0] word;
  } fetch_req_t;

  // --------------------------------------------------
  // buffer state and classification
  // --------------------------------------------------
  typedef struct packed {
    logic      vld;
    logic      acc_err;
    halfword_t inst;
  } entry_t;

  typedef struct packed {
    logic h0_vld;
    logic h1_16;
    logic h1_32;
    logic h2_16;
    logic h2_32;
  } slot_class_t;

  // --------------------------------------------------
  // output side
  // --------------------------------------------------
  typedef struct packed {
    halfword_t   third;
    logic [31:0] first;
  } window_split_t;

  // halves[2] is always entry2, halves[0] the lowest parcel handed out
  typedef union packed {
    halfword_t [2:0] halves;
    window_split_t   split;
  } retire_window_u;

  // none of one/two/all set means a single 32-bit instruction
  typedef struct packed {
    logic           vld;
    logic           one;
    logic           two;
    logic           all;
    logic [2:0]     acc_err;
    retire_window_u window;
  } ibuf_req_t;

endpackage

// File: rtl/ipack_retire.sv
// output side of the packer; all outputs combinational from entries, stall and raw fetch valid
`timescale 1ns/1ns

module ipack_retire (
  input  ipack_pkg::entry_t [ipack_pkg::ENTRY_CNT-1:0] entries,
  input  ipack_pkg::slot_class_t                       slot_class,
  input  logic                                         ibuf_stall,
  input  logic                                         fetch_vld,
  output ipack_pkg::ibuf_req_t                         ibuf_req,
  output logic                                         ibuf_empty,
  output logic                                         ibuf_full,
  output logic                                         pcgen_reissue
);

  logic                      e0_vld;
  logic                      e1_vld;
  logic                      h0_vld;
  logic                      retire_vld;
  ipack_pkg::retire_window_u window;

  assign e0_vld = entries[0].vld;
  assign e1_vld = entries[1].vld;
  assign h0_vld = slot_class.h0_vld;

  // --------------------------------------------------
  // instruction window
  // --------------------------------------------------
  always_comb begin
    window.halves[2] = entries[2].inst;
    if (e0_vld) begin
      window.split.first = {entries[1].inst, entries[0].inst};
    end else if (e1_vld) begin
      window.split.first = {entries[2].inst, entries[1].inst};
    end else begin
      // lone high half, repeated so the low parcel is always in place
      window.split.first = {entries[2].inst, entries[2].inst};
    end
  end

  // --------------------------------------------------
  // count code
  // --------------------------------------------------
  assign retire_vld = e1_vld | slot_class.h2_16;

  assign ibuf_req.vld = retire_vld & ~ibuf_stall;

  assign ibuf_req.two = (h0_vld | slot_class.h1_16) & slot_class.h2_16;

  assign ibuf_req.one = (~h0_vld & slot_class.h1_16 & ~slot_class.h2_16)
                      | (~e1_vld & slot_class.h2_16);

  // carried 32-bit op plus a trailing 16-bit parcel
  assign ibuf_req.all = h0_vld & e1_vld & slot_class.h2_16;

  assign ibuf_req.window = window;

  // --------------------------------------------------
  // access errors per retired parcel
  // --------------------------------------------------
  assign ibuf_req.acc_err[0] = (~h0_vld & e1_vld & entries[1].acc_err)
                             | (~e1_vld & slot_class.h2_16 & entries[2].acc_err)
                             | (h0_vld & e1_vld & entries[0].acc_err);

  assign ibuf_req.acc_err[1] = (~h0_vld & slot_class.h1_32 & entries[2].vld
                                & entries[2].acc_err)
                             | (~h0_vld & slot_class.h1_16 & slot_class.h2_16
                                & entries[2].acc_err)
                             | (h0_vld & e1_vld & entries[1].acc_err);

  assign ibuf_req.acc_err[2] = ibuf_req.all & entries[2].acc_err;

  // --------------------------------------------------
  // status and reissue
  // --------------------------------------------------
  assign ibuf_empty = ~entries[0].vld & ~entries[1].vld & ~entries[2].vld;
  assign ibuf_full  =  entries[0].vld &  entries[1].vld &  entries[2].vld;

  // raw fetch, before masking, so the pc generator replays it
  assign pcgen_reissue = ibuf_stall & fetch_vld;

endmodule

// File: rtl/ipack_top.sv
// packer top level; one-cycle fetch-to-window latency, no handshake beyond the stall level
`timescale 1ns/1ns

module ipack_top (
  input  logic                  forever_cpuclk,
  input  logic                  rst_n,
  input  ipack_pkg::fetch_req_t fetch,
  input  logic                  pcgen_chgflw,
  input  logic                  inst_mask,
  input  ipack_pkg::flush_src_t flush_src,
  input  logic                  ibuf_stall,
  output ipack_pkg::ibuf_req_t  ibuf_req,
  output logic                  ibuf_empty,
  output logic                  ibuf_full,
  output logic                  pcgen_reissue
);

  ipack_pkg::fetch_req_t                        fetch_q;
  logic                                         buf_flush;
  ipack_pkg::entry_t [ipack_pkg::ENTRY_CNT-1:0] entries;
  ipack_pkg::slot_class_t                       slot_class;

  // --------------------------------------------------
  // input qualification and flush merge
  // --------------------------------------------------
  ipack_fetch_in u_fetch_in (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .fetch          (fetch),
    .pcgen_chgflw   (pcgen_chgflw),
    .inst_mask      (inst_mask),
    .flush_src      (flush_src),
    .fetch_q        (fetch_q),
    .buf_flush      (buf_flush)
  );

  // --------------------------------------------------
  // length decode of the held parcels
  // --------------------------------------------------
  ipack_len_decode u_len_decode (
    .entries    (entries),
    .slot_class (slot_class)
  );

  // --------------------------------------------------
  // entry storage
  // --------------------------------------------------
  ipack_hw_buf u_hw_buf (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .fetch_q        (fetch_q),
    .buf_flush      (buf_flush),
    .ibuf_stall     (ibuf_stall),
    .slot_class     (slot_class),
    .entries        (entries)
  );

  // --------------------------------------------------
  // window, count and status toward the buffer
  // --------------------------------------------------
  // reissue looks at the fetch before masking
  ipack_retire u_retire (
    .entries       (entries),
    .slot_class    (slot_class),
    .ibuf_stall    (ibuf_stall),
    .fetch_vld     (fetch.vld),
    .ibuf_req      (ibuf_req),
    .ibuf_empty    (ibuf_empty),
    .ibuf_full     (ibuf_full),
    .pcgen_reissue (pcgen_reissue)
  );

endmodule
